// File: core_pkg.sv
package core_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_idx_t;

    localparam xlen_t default_pc  = 32'h0000_0000;
    localparam xlen_t default_pc4 = 32'h0000_0004;
    localparam xlen_t zero_word   = 32'h0000_0000;

    localparam logic [6:0] opcode_op     = 7'b0110011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;
    localparam logic [6:0] opcode_lui    = 7'b0110111;
    localparam logic [6:0] opcode_auipc  = 7'b0010111;
    localparam logic [6:0] opcode_jal    = 7'b1101111;
    localparam logic [6:0] opcode_jalr   = 7'b1100111;
    localparam logic [6:0] opcode_branch = 7'b1100011;

    typedef enum logic [3:0] {
        ir_r_alu   = 4'd0,
        ir_i_alu   = 4'd1,
        ir_lui     = 4'd2,
        ir_auipc   = 4'd3,
        ir_jal     = 4'd4,
        ir_jalr    = 4'd5,
        ir_branch  = 4'd6,
        ir_invalid = 4'd7
    } ir_type_t;

    typedef struct packed {
        xlen_t pc;
        xlen_t instr;
        logic  jump_prediction;
        xlen_t addr_prediction; // only meaningful when a jump is predicted.
    } fetch_pkt_t;

    typedef struct packed {
        xlen_t      pc;
        xlen_t      pc4;
        xlen_t      data1;
        xlen_t      data2;
        logic [6:0] funct7;
        logic [2:0] funct3;
        reg_idx_t   rs2;
        reg_idx_t   rd;
        ir_type_t   ir_type;
        xlen_t      z;
        logic       wr_reg_n;
        logic       flush; // a dead slot that must not write or redirect.
        logic       jump_prediction;
        xlen_t      addr_prediction;
        xlen_t      in1;
        xlen_t      in2;
    } id_ex_t;

    typedef struct packed {
        reg_idx_t rd;
        xlen_t    value;
        logic     wr_reg_n;
    } wb_t;

    localparam id_ex_t id_ex_default = '{
        pc: default_pc, pc4: default_pc4, data1: zero_word, data2: zero_word,
        funct7: 7'd0, funct3: 3'd0, rs2: 5'd0, rd: 5'd0, ir_type: ir_invalid,
        z: zero_word, wr_reg_n: 1'b1, flush: 1'b1, jump_prediction: 1'b0,
        addr_prediction: default_pc4, in1: zero_word, in2: zero_word
    };

    localparam wb_t wb_default = '{rd: 5'd0, value: zero_word, wr_reg_n: 1'b1};

endpackage

// File: reg_file.sv
`timescale 1ns/1ps

module reg_file
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output xlen_t    rd1,
    output xlen_t    rd2,
    input  wb_t      wb
);

    xlen_t regs [32];
    logic  wr_en;

    assign wr_en = !wb.wr_reg_n && (wb.rd != 5'd0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= zero_word;
            end
        end else if (wr_en) begin
            regs[wb.rd] <= wb.value;
        end
    end

    // the retiring value is forwarded so decode sees it in the same cycle.
    always_comb begin
        rd1 = (wr_en && wb.rd == rs1) ? wb.value : regs[rs1];
        rd2 = (wr_en && wb.rd == rs2) ? wb.value : regs[rs2];
        if (rs1 == 5'd0) begin
            rd1 = zero_word;
        end
        if (rs2 == 5'd0) begin
            rd2 = zero_word;
        end
    end

endmodule

// File: hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall,
    input  reg_idx_t dec_rs1,
    input  reg_idx_t dec_rs2,
    input  logic     dec_uses_rs1,
    input  logic     dec_uses_rs2,
    input  reg_idx_t ex_rd,
    input  logic     ex_wr_reg_n,
    output logic     interlock
);

    logic rs1_hit;
    logic rs2_hit;

    // x0 never carries a dependency.
    assign rs1_hit = dec_uses_rs1 && (dec_rs1 == ex_rd);
    assign rs2_hit = dec_uses_rs2 && (dec_rs2 == ex_rd);

    assign interlock = !ex_wr_reg_n && (ex_rd != 5'd0) && (rs1_hit || rs2_hit);

    // the bubble left in ID/EX must clear the dependency after one cycle.
    a_interlock_once: assert property (
        @(posedge clk) disable iff (!rst_n)
        interlock |=> (!interlock || stall)
    ) else $error("interlock held for two cycles without a stall.");

endmodule

// File: decode_stage.sv
`timescale 1ns/1ps

module decode_stage
    import core_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       fetch_valid,
    input  fetch_pkt_t fetch,
    input  logic       hold,
    input  logic       redirect_valid,
    input  xlen_t      rd1,
    input  xlen_t      rd2,
    output reg_idx_t   rs1,
    output reg_idx_t   rs2,
    output logic       uses_rs1,
    output logic       uses_rs2,
    output id_ex_t     dec
);

    fetch_pkt_t pkt;
    logic       pkt_valid;
    xlen_t      instr;
    ir_type_t   ir_type;
    xlen_t      imm;
    logic       live;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pkt_valid <= 1'b0;
        end else if (redirect_valid) begin
            pkt_valid <= 1'b0; // the slot holds a wrong-path instruction.
        end else if (!hold) begin
            pkt_valid <= fetch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid && !hold) begin
            pkt <= fetch;
        end
    end

    assign instr = pkt.instr;
    assign live  = pkt_valid && (ir_type != ir_invalid);
    assign rs1   = instr[19:15];
    assign rs2   = instr[24:20];

    always_comb begin
        case (instr[6:0])
            opcode_op:     ir_type = ir_r_alu;
            opcode_op_imm: ir_type = ir_i_alu;
            opcode_lui:    ir_type = ir_lui;
            opcode_auipc:  ir_type = ir_auipc;
            opcode_jal:    ir_type = ir_jal;
            opcode_jalr:   ir_type = ir_jalr;
            opcode_branch: ir_type = ir_branch;
            default:       ir_type = ir_invalid;
        endcase
    end

    always_comb begin
        case (ir_type)
            ir_i_alu, ir_jalr: imm = {{20{instr[31]}}, instr[31:20]};
            ir_lui, ir_auipc:  imm = {instr[31:12], 12'd0};
            ir_jal:    imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            ir_branch: imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            default:   imm = zero_word;
        endcase
    end

    assign uses_rs1 = live && (ir_type inside {ir_r_alu, ir_i_alu, ir_jalr, ir_branch});
    assign uses_rs2 = live && (ir_type inside {ir_r_alu, ir_branch});

    always_comb begin
        dec.pc              = pkt.pc;
        dec.pc4             = pkt.pc + 32'd4;
        dec.data1           = rd1;
        dec.data2           = rd2;
        dec.funct7          = instr[31:25];
        dec.funct3          = instr[14:12];
        dec.rs2             = instr[24:20];
        dec.rd              = instr[11:7];
        dec.ir_type         = ir_type;
        dec.z               = imm;
        dec.flush           = !live || redirect_valid;
        dec.wr_reg_n        = dec.flush || (ir_type == ir_branch);
        dec.jump_prediction = pkt.jump_prediction;
        dec.addr_prediction = pkt.addr_prediction;
        case (ir_type)
            ir_lui:         dec.in1 = zero_word;
            ir_auipc, ir_jal: dec.in1 = pkt.pc; // jal target comes out of the adder.
            default:        dec.in1 = rd1;
        endcase
        dec.in2 = (ir_type inside {ir_r_alu, ir_branch}) ? rd2 : imm;
    end

endmodule

// File: id_ex_regs.sv
`timescale 1ns/1ps

module id_ex_regs
    import core_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   stall,
    input  logic   interlock,
    input  id_ex_t d,
    output id_ex_t q
);

    logic stall_or_interlock;

    assign stall_or_interlock = stall || interlock;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= id_ex_default;
        end else if (stall_or_interlock) begin
            // fields stay put, but the slot turns into a bubble.
            // Without this the same dependency would be seen again and never clear.
            q.wr_reg_n <= 1'b1;
            q.flush    <= 1'b1;
        end else begin
            q <= d;
        end
    end

    a_bubble_after_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        stall_or_interlock |=> (q.wr_reg_n && q.flush)
    ) else $error("ID/EX slot still live after a hold.");

endmodule

// File: execute_stage.sv
`timescale 1ns/1ps

module execute_stage
    import core_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  id_ex_t ex,
    output logic   redirect_valid,
    output xlen_t  redirect_target,
    output logic   retire_valid,
    output wb_t    retire
);

    logic [2:0] alu_op;
    logic       alt;
    xlen_t      alu_result;
    xlen_t      target;
    xlen_t      wb_value;
    logic       cond;
    logic       taken;
    logic       is_jump;
    logic       mispredict;

    assign is_jump = (ex.ir_type == ir_jal) || (ex.ir_type == ir_jalr);

    // lui, auipc and jumps all go through the adder.
    assign alu_op = (ex.ir_type inside {ir_r_alu, ir_i_alu}) ? ex.funct3 : 3'b000;
    assign alt    = ex.funct7[5] &&
                    ((ex.ir_type == ir_r_alu) || (ex.ir_type == ir_i_alu && alu_op == 3'b101));

    always_comb begin
        case (alu_op)
            3'b000: alu_result = alt ? ex.in1 - ex.in2 : ex.in1 + ex.in2;
            3'b001: alu_result = ex.in1 << ex.in2[4:0];
            3'b010: alu_result = {31'd0, $signed(ex.in1) < $signed(ex.in2)};
            3'b011: alu_result = {31'd0, ex.in1 < ex.in2};
            3'b100: alu_result = ex.in1 ^ ex.in2;
            3'b101: begin
                if (alt) begin
                    alu_result = $signed(ex.in1) >>> ex.in2[4:0];
                end else begin
                    alu_result = ex.in1 >> ex.in2[4:0];
                end
            end
            3'b110: alu_result = ex.in1 | ex.in2;
            default: alu_result = ex.in1 & ex.in2;
        endcase
    end

    always_comb begin
        case (ex.funct3)
            3'b000: cond = (ex.data1 == ex.data2);
            3'b001: cond = (ex.data1 != ex.data2);
            3'b100: cond = ($signed(ex.data1) < $signed(ex.data2));
            3'b101: cond = ($signed(ex.data1) >= $signed(ex.data2));
            3'b110: cond = (ex.data1 < ex.data2);
            3'b111: cond = (ex.data1 >= ex.data2);
            default: cond = 1'b0;
        endcase
    end

    assign taken  = is_jump || ((ex.ir_type == ir_branch) && cond);
    assign target = is_jump ? {alu_result[31:1], 1'b0} : ex.pc + ex.z;

    // the address prediction only matters when the jump was taken.
    assign mispredict = (taken != ex.jump_prediction) ||
                        (taken && (target != ex.addr_prediction));

    assign redirect_valid  = mispredict && !ex.flush;
    assign redirect_target = taken ? target : ex.pc4;
    assign wb_value        = is_jump ? ex.pc4 : alu_result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
            retire       <= wb_default;
        end else begin
            retire_valid    <= !ex.flush;
            retire.rd       <= ex.rd;
            retire.value    <= wb_value;
            retire.wr_reg_n <= ex.wr_reg_n || ex.flush;
        end
    end

    a_flush_after_redirect: assert property (
        @(posedge clk) disable iff (!rst_n)
        redirect_valid |=> (ex.flush && !redirect_valid)
    ) else $error("redirect not followed by a flushed slot.");

endmodule

// File: core_backend.sv
`timescale 1ns/1ps

module core_backend
    import core_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       fetch_valid,
    input  fetch_pkt_t fetch,
    input  logic       stall,
    output logic       hold,
    output logic       redirect_valid,
    output xlen_t      redirect_target,
    output logic       retire_valid,
    output wb_t        retire
);

    reg_idx_t rs1;
    reg_idx_t rs2;
    xlen_t    rd1;
    xlen_t    rd2;
    logic     uses_rs1;
    logic     uses_rs2;
    logic     interlock;
    id_ex_t   dec;
    id_ex_t   ex;

    assign hold = stall || interlock; // the fetch source waits while this is high.

    reg_file u_reg_file (
        .clk (clk), .rst_n (rst_n),
        .rs1 (rs1), .rs2 (rs2), .rd1 (rd1), .rd2 (rd2),
        .wb  (retire)
    );

    hazard_unit u_hazard_unit (
        .clk          (clk),      .rst_n        (rst_n),    .stall (stall),
        .dec_rs1      (rs1),      .dec_rs2      (rs2),
        .dec_uses_rs1 (uses_rs1), .dec_uses_rs2 (uses_rs2),
        .ex_rd        (ex.rd),    .ex_wr_reg_n  (ex.wr_reg_n),
        .interlock    (interlock)
    );

    decode_stage u_decode_stage (
        .clk (clk), .rst_n (rst_n), .fetch_valid (fetch_valid), .fetch (fetch),
        .hold (hold), .redirect_valid (redirect_valid), .rd1 (rd1), .rd2 (rd2),
        .rs1 (rs1), .rs2 (rs2), .uses_rs1 (uses_rs1), .uses_rs2 (uses_rs2), .dec (dec)
    );

    id_ex_regs u_id_ex_regs (
        .clk (clk), .rst_n (rst_n), .stall (stall), .interlock (interlock),
        .d   (dec), .q     (ex)
    );

    execute_stage u_execute_stage (
        .clk (clk), .rst_n (rst_n), .ex (ex),
        .redirect_valid (redirect_valid), .redirect_target (redirect_target),
        .retire_valid   (retire_valid),   .retire          (retire)
    );

endmodule

// File: tb_core_backend.sv
`timescale 1ns/1ps

module tb_core_backend
    import core_pkg::*;
();

    logic       clk;
    logic       rst_n;
    logic       fetch_valid;
    fetch_pkt_t fetch;
    logic       stall;
    logic       hold;
    logic       redirect_valid;
    xlen_t      redirect_target;
    logic       retire_valid;
    wb_t        retire;

    xlen_t    m_regs [32];
    xlen_t    pc;
    int       seed;
    logic     started;
    reg_idx_t exp_rd [256];
    xlen_t    exp_val [256];
    logic     exp_wrn [256];
    xlen_t    exp_target [64];
    int       exp_wr;
    int       exp_rd_ptr;
    int       red_wr;
    int       red_rd;

    core_backend uut (
        .clk (clk), .rst_n (rst_n), .fetch_valid (fetch_valid), .fetch (fetch),
        .stall (stall), .hold (hold), .redirect_valid (redirect_valid),
        .redirect_target (redirect_target), .retire_valid (retire_valid), .retire (retire)
    );

    always #50 clk = ~clk;

    task automatic finish_failed();
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic value_error(input string msg);
        $display("ERR %0t: %s", $time, msg);
        finish_failed();
    endtask

    task automatic run_error(input string msg);
        $display("%s", msg);
        finish_failed();
    endtask

    a_quiet_after_reset: assert property (
        @(posedge clk) disable iff (!rst_n)
        !started |-> (!retire_valid && !redirect_valid && !hold)
    ) else value_error("activity before the first fetch strobe");

    a_retire_order: assert property (
        @(posedge clk) disable iff (!rst_n)
        retire_valid |-> ((exp_rd_ptr < exp_wr) && (retire.wr_reg_n == exp_wrn[exp_rd_ptr]) &&
            (retire.wr_reg_n || (retire.rd == exp_rd[exp_rd_ptr] &&
                                 retire.value == exp_val[exp_rd_ptr])))
    ) else value_error("retirement differs from the reference model");

    a_redirect_target: assert property (
        @(posedge clk) disable iff (!rst_n)
        redirect_valid |-> ((red_rd < red_wr) && (redirect_target == exp_target[red_rd]))
    ) else value_error("unexpected redirect or wrong redirect target");

    a_interlock_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        (hold && !stall) |=> (!hold || stall)
    ) else value_error("hold lasted more than one cycle without a stall");

    a_hold_follows_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        stall |-> hold
    ) else value_error("hold low while stall is high");

    // an accepted strobe with no hold behind it retires two edges later.
    a_retire_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        (fetch_valid && !hold) ##1 (!hold && !redirect_valid) |=> ##1 retire_valid
    ) else value_error("no retirement two edges after an accepted strobe");

    a_interlock_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        (fetch_valid && !hold) ##1 (hold && !stall && !redirect_valid) ##1 !hold
            |=> ##1 retire_valid
    ) else value_error("interlocked instruction not retired one cycle late");

    always @(posedge clk) begin
        if (rst_n && retire_valid) begin
            exp_rd_ptr <= exp_rd_ptr + 1;
        end
        if (rst_n && redirect_valid) begin
            red_rd <= red_rd + 1;
        end
    end

    function automatic xlen_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3,
                                    input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic xlen_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                    input logic [2:0] f3, input reg_idx_t rd,
                                    input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic xlen_t enc_j(input logic [20:0] off, input reg_idx_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic xlen_t enc_b(input logic [12:0] off, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic xlen_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input xlen_t a, input xlen_t b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: return (a < b) ? 32'd1 : 32'd0;
            3'b100: return a ^ b;
            3'b101: return alt ? xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    // executes one instruction on the model and queues its retirement.
    task automatic model_exec(input xlen_t instr, output xlen_t next_pc, output logic taken);
        xlen_t      a;
        xlen_t      b;
        xlen_t      imm_i;
        xlen_t      val;
        logic [2:0] f3;
        logic       is_branch;
        a = m_regs[instr[19:15]];
        b = m_regs[instr[24:20]];
        f3 = instr[14:12];
        imm_i = {{20{instr[31]}}, instr[31:20]};
        taken = 1'b0;
        next_pc = pc + 32'd4;
        is_branch = (instr[6:0] == 7'b1100011);
        val = zero_word;
        case (instr[6:0])
            7'b0110011: val = alu_ref(f3, instr[30], a, b);
            7'b0010011: val = alu_ref(f3, instr[30] && f3 == 3'b101, a, imm_i);
            7'b0110111: val = {instr[31:12], 12'd0};
            7'b0010111: val = pc + {instr[31:12], 12'd0};
            7'b1101111: begin
                val = pc + 32'd4;
                taken = 1'b1;
                next_pc = pc + {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            7'b1100111: begin
                val = pc + 32'd4;
                taken = 1'b1;
                next_pc = (a + imm_i) & ~32'd1;
            end
            default: begin
                case (f3)
                    3'b000: taken = (a == b);
                    3'b001: taken = (a != b);
                    3'b100: taken = ($signed(a) < $signed(b));
                    3'b101: taken = ($signed(a) >= $signed(b));
                    3'b110: taken = (a < b);
                    default: taken = (a >= b);
                endcase
                if (taken) begin
                    next_pc = pc + {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
                end
            end
        endcase
        exp_rd[exp_wr] = instr[11:7];
        exp_val[exp_wr] = val;
        exp_wrn[exp_wr] = is_branch;
        exp_wr++;
        if (!is_branch && instr[11:7] != 5'd0) begin
            m_regs[instr[11:7]] = val;
        end
    endtask

    task automatic strobe(input xlen_t instr, input logic pred, input xlen_t paddr);
        int n;
        n = 0;
        while (hold) begin
            fetch_valid = 1'b0;
            @(negedge clk);
            n++;
            if (n > 50) begin
                run_error("timeout: hold never dropped");
            end
        end
        fetch_valid = 1'b1;
        fetch = '{pc: pc, instr: instr, jump_prediction: pred, addr_prediction: paddr};
        started = 1'b1;
        @(negedge clk);
        fetch_valid = 1'b0;
    endtask

    task automatic wait_redirect();
        int n;
        n = 0;
        while (!redirect_valid) begin
            @(negedge clk);
            n++;
            if (n > 20) begin
                run_error("timeout: no redirect after a wrong prediction");
            end
        end
        @(negedge clk); // the redirect cycle itself carries no strobe.
    endtask

    task automatic run(input xlen_t instr, input logic pred, input xlen_t paddr);
        xlen_t next_pc;
        logic  taken;
        model_exec(instr, next_pc, taken);
        strobe(instr, pred, paddr);
        if ((taken != pred) || (taken && next_pc != paddr)) begin
            exp_target[red_wr] = next_pc;
            red_wr++;
            pc = pred ? paddr : pc + 32'd4;
            strobe(enc_i(12'h07b, 5'd0, 3'b000, 5'd10, opcode_op_imm), 1'b0, zero_word);
            wait_redirect();
        end
        pc = next_pc;
    endtask

    initial begin
        logic [31:0] r;
        logic [2:0]  f3;
        logic        alt;
        int          n;
        clk = 1'b0;
        rst_n = 1'b0;
        fetch_valid = 1'b0;
        fetch = '0;
        stall = 1'b0;
        started = 1'b0;
        seed = 32'hb5d;
        pc = 32'h0000_0100;
        exp_wr = 0;
        exp_rd_ptr = 0;
        red_wr = 0;
        red_rd = 0;
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = zero_word;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (3) @(negedge clk);

        r = $random(seed);
        run({r[31:12], 5'd1, opcode_lui}, 1'b0, zero_word);
        r = $random(seed);
        run(enc_i(r[11:0], 5'd0, 3'b000, 5'd2, opcode_op_imm), 1'b0, zero_word);
        r = $random(seed);
        run({r[31:12], 5'd3, opcode_auipc}, 1'b0, zero_word);
        r = $random(seed);
        run(enc_i(r[11:0], 5'd0, 3'b000, 5'd4, opcode_op_imm), 1'b0, zero_word);
        run(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd5), 1'b0, zero_word);
        run(enc_r(7'h20, 5'd4, 5'd5, 3'b000, 5'd6), 1'b0, zero_word); // reads x5 from EX.

        for (int k = 0; k < 10; k++) begin
            r = $random(seed);
            f3 = r[2:0];
            alt = r[3] && (f3 == 3'b000 || f3 == 3'b101);
            run(enc_r({1'b0, alt, 5'd0}, 5'(r[6:4] % 6 + 1),
                      r[10] ? 5'(10 + k) : 5'(r[9:7] % 6 + 1), f3, 5'(11 + k)),
                1'b0, zero_word);
        end
        run(enc_i(12'h403, 5'd20, 3'b101, 5'd21, opcode_op_imm), 1'b0, zero_word);

        run(enc_j(21'd8, 5'd7), 1'b1, pc + 32'd8);
        run(enc_j(21'd12, 5'd8), 1'b0, zero_word);
        run(enc_b(13'd16, 5'd1, 5'd1, 3'b000), 1'b0, zero_word);
        run(enc_b(13'd8, 5'd0, 5'd0, 3'b001), 1'b0, zero_word);
        run(enc_b(13'd16, 5'd0, 5'd0, 3'b000), 1'b1, pc + 32'd16);
        run(enc_b(13'd24, 5'd2, 5'd1, 3'b100), 1'b0, zero_word);
        run(enc_i(12'd4, 5'd2, 3'b000, 5'd9, opcode_jalr), 1'b1, m_regs[2] + 32'd12);

        run(enc_i(12'd5, 5'd1, 3'b000, 5'd22, opcode_op_imm), 1'b0, zero_word);
        run(enc_i(12'd7, 5'd2, 3'b000, 5'd23, opcode_op_imm), 1'b0, zero_word);
        stall = 1'b1;
        repeat (5) @(negedge clk);
        stall = 1'b0;
        run(enc_r(7'h00, 5'd23, 5'd22, 3'b000, 5'd24), 1'b0, zero_word);
        run(enc_r(7'h00, 5'd24, 5'd22, 3'b111, 5'd25), 1'b0, zero_word);

        n = 0;
        while (exp_rd_ptr < exp_wr) begin
            @(negedge clk);
            n++;
            if (n > 50) begin
                run_error("timeout: not every instruction retired");
            end
        end
        repeat (3) @(negedge clk);
        if (red_rd != red_wr || exp_rd_ptr != exp_wr) begin
            $display("redirect or retirement count differs from the model");
            $display("Result: FAILED");
            $fatal(1);
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

// File: src.f
core_pkg.sv
reg_file.sv
hazard_unit.sv
decode_stage.sv
id_ex_regs.sv
execute_stage.sv
core_backend.sv
tb_core_backend.sv
